// File: logic/gfx_settings.svh
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// Visible screen size in pixels
`define GFX_FB_WIDTH  16
`define GFX_FB_HEIGHT 12

// Depth of the address FIFO
// The stepper starts out with this many credits
`define GFX_CREDITS   4

`endif

// File: logic/gfx_pkg.sv
package gfx_pkg;

  // Signed so that endpoints may lie left of or above the screen
  typedef logic signed [9:0] coord_t;

  typedef logic [31:0] color_t;

  // Frame-buffer word address
  typedef logic [15:0] fb_addr_t;

  // Register select of a command write
  typedef logic [2:0] cmd_sel_t;

  localparam cmd_sel_t SEL_COLOR = 3'd0;
  localparam cmd_sel_t SEL_X0    = 3'd1;
  localparam cmd_sel_t SEL_Y0    = 3'd2;
  localparam cmd_sel_t SEL_X1    = 3'd3;
  localparam cmd_sel_t SEL_Y1    = 3'd4;
  localparam cmd_sel_t SEL_LINE  = 3'd5;
  localparam cmd_sel_t SEL_FILL  = 3'd6;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LINE,
    ST_FILL
  } step_state_t;

endpackage

// File: logic/pixel_if.sv
`timescale 1ns/1ps

// Pixel beats downstream, credits back upstream
interface pixel_if;
  import gfx_pkg::*;

  logic   valid;
  coord_t x;
  coord_t y;
  color_t color;

  // One pulse per FIFO entry that left on the frame-buffer port
  logic   credit;

  modport src (
    output valid,
    output x,
    output y,
    output color,
    input  credit
  );

  modport dst (
    input  valid,
    input  x,
    input  y,
    input  color,
    output credit
  );

endinterface

// File: logic/gfx_cmd_regs.sv
`timescale 1ns/1ps

module gfx_cmd_regs (
  input  logic              cpu_clk_g,
  input  logic              rst_n,
  input  logic              cmd_valid,
  input  gfx_pkg::cmd_sel_t cmd_sel,
  input  logic [31:0]       cmd_data,
  input  logic              engine_busy,
  output gfx_pkg::color_t   color,
  output gfx_pkg::coord_t   x0,
  output gfx_pkg::coord_t   y0,
  output gfx_pkg::coord_t   x1,
  output gfx_pkg::coord_t   y1,
  output logic              start_line,
  output logic              start_fill
);
  import gfx_pkg::*;

  coord_t cmd_coord;

  // Coordinates use the low bits of the data word only
  assign cmd_coord = coord_t'(cmd_data[9:0]);

  always_ff @(posedge cpu_clk_g or negedge rst_n) begin
    if (!rst_n) begin
      color <= '0;
      x0    <= '0;
      y0    <= '0;
      x1    <= '0;
      y1    <= '0;
    end else if (cmd_valid) begin
      case (cmd_sel)
        SEL_COLOR: color <= cmd_data;
        SEL_X0:    x0    <= cmd_coord;
        SEL_Y0:    y0    <= cmd_coord;
        SEL_X1:    x1    <= cmd_coord;
        SEL_Y1:    y1    <= cmd_coord;
        default:   ;
      endcase
    end
  end

  // Triggers while the engine is busy are dropped here and nowhere else
  always_ff @(posedge cpu_clk_g or negedge rst_n) begin
    if (!rst_n) begin
      start_line <= 1'b0;
      start_fill <= 1'b0;
    end else begin
      start_line <= cmd_valid && (cmd_sel == SEL_LINE) && !engine_busy;
      start_fill <= cmd_valid && (cmd_sel == SEL_FILL) && !engine_busy;
    end
  end

endmodule

// File: logic/line_stepper.sv
`timescale 1ns/1ps
`include "gfx_settings.svh"

module line_stepper (
  input  logic            cpu_clk_g,
  input  logic            rst_n,
  input  logic            start_line,
  input  logic            start_fill,
  input  gfx_pkg::color_t color,
  input  gfx_pkg::coord_t x0,
  input  gfx_pkg::coord_t y0,
  input  gfx_pkg::coord_t x1,
  input  gfx_pkg::coord_t y1,
  pixel_if.src            pix,
  output logic            stepping
);
  import gfx_pkg::*;

  localparam coord_t SCR_W  = coord_t'(`GFX_FB_WIDTH);
  localparam coord_t SCR_H  = coord_t'(`GFX_FB_HEIGHT);
  localparam coord_t LAST_X = coord_t'(`GFX_FB_WIDTH - 1);
  localparam coord_t LAST_Y = coord_t'(`GFX_FB_HEIGHT - 1);
  localparam int     CW     = $clog2(`GFX_CREDITS + 1);

  step_state_t        state;
  coord_t             cur_x, cur_y;
  coord_t             end_x, end_y;
  color_t             color_q;
  logic               neg_x, neg_y;
  logic signed [12:0] dx_q, dy_q, err_q, e2;
  logic signed [12:0] diff_x, diff_y, abs_x, abs_y;
  logic [CW-1:0]      credits;
  logic               on_screen, advance, last_pix, step_x, step_y;

  // Setup values for a new line come straight from the endpoints
  assign diff_x = x1 - x0;
  assign diff_y = y1 - y0;
  assign abs_x  = diff_x[12] ? -diff_x : diff_x;
  assign abs_y  = diff_y[12] ? -diff_y : diff_y;

  // Bresenham decision terms
  assign e2     = err_q <<< 1;
  assign step_x = (e2 >= dy_q);
  assign step_y = (e2 <= dx_q);

  assign on_screen = (cur_x >= 0) && (cur_x < SCR_W) && (cur_y >= 0) && (cur_y < SCR_H);

  // Off-screen pixels move on without waiting for a credit
  assign advance = (state != ST_IDLE) && (!on_screen || (credits != '0));

  assign last_pix = (state == ST_FILL) ? ((cur_x == LAST_X) && (cur_y == LAST_Y)) :
                                         ((cur_x == end_x) && (cur_y == end_y));

  assign pix.valid = (state != ST_IDLE) && on_screen && (credits != '0);
  assign pix.x     = cur_x;
  assign pix.y     = cur_y;
  assign pix.color = color_q;

  // Covers the start pulse cycle so busy has no gap
  assign stepping = (state != ST_IDLE) || start_line || start_fill;

  always_ff @(posedge cpu_clk_g or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CW'(`GFX_CREDITS);
    end else begin
      case ({pix.credit, pix.valid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge cpu_clk_g or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      cur_x   <= '0;
      cur_y   <= '0;
      end_x   <= '0;
      end_y   <= '0;
      color_q <= '0;
      neg_x   <= 1'b0;
      neg_y   <= 1'b0;
      dx_q    <= '0;
      dy_q    <= '0;
      err_q   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start_line) begin
            cur_x   <= x0;
            cur_y   <= y0;
            end_x   <= x1;
            end_y   <= y1;
            color_q <= color;
            neg_x   <= diff_x[12];
            neg_y   <= diff_y[12];
            dx_q    <= abs_x;
            dy_q    <= -abs_y;
            err_q   <= abs_x - abs_y;
            state   <= ST_LINE;
          end else if (start_fill) begin
            cur_x   <= '0;
            cur_y   <= '0;
            color_q <= color;
            state   <= ST_FILL;
          end
        end
        ST_LINE: begin
          if (advance && last_pix) begin
            state <= ST_IDLE;
          end else if (advance) begin
            if (step_x) begin
              cur_x <= neg_x ? cur_x - coord_t'(1) : cur_x + coord_t'(1);
            end
            if (step_y) begin
              cur_y <= neg_y ? cur_y - coord_t'(1) : cur_y + coord_t'(1);
            end
            err_q <= err_q + (step_x ? dy_q : 13'sd0) + (step_y ? dx_q : 13'sd0);
          end
        end
        ST_FILL: begin
          if (advance && last_pix) begin
            state <= ST_IDLE;
          end else if (advance) begin
            // Row-major sweep
            if (cur_x == LAST_X) begin
              cur_x <= '0;
              cur_y <= cur_y + coord_t'(1);
            end else begin
              cur_x <= cur_x + coord_t'(1);
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: logic/pixel_addr_gen.sv
`timescale 1ns/1ps
`include "gfx_settings.svh"

module pixel_addr_gen (
  input  logic              cpu_clk_g,
  input  logic              rst_n,
  pixel_if.dst              pix,
  output logic              fb_we,
  output gfx_pkg::fb_addr_t fb_addr,
  output gfx_pkg::color_t   fb_data,
  input  logic              fb_ready,
  output logic              draining
);
  import gfx_pkg::*;

  localparam int DEPTH = `GFX_CREDITS;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  fb_addr_t      addr_mem [DEPTH];
  color_t        data_mem [DEPTH];
  logic [PW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  fb_addr_t      addr_in;
  logic          pop;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Row-major word address
  assign addr_in = fb_addr_t'(pix.y) * fb_addr_t'(`GFX_FB_WIDTH) + fb_addr_t'(pix.x);

  // Head of the FIFO sits on the port until it is taken
  assign fb_we    = (count != '0);
  assign fb_addr  = addr_mem[rd_ptr];
  assign fb_data  = data_mem[rd_ptr];
  assign pop      = fb_we && fb_ready;
  assign draining = fb_we;

  // Credits keep the FIFO from overflowing, so a beat is always written
  always_ff @(posedge cpu_clk_g) begin
    if (pix.valid) begin
      addr_mem[wr_ptr] <= addr_in;
      data_mem[wr_ptr] <= pix.color;
    end
  end

  always_ff @(posedge cpu_clk_g or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      pix.credit <= 1'b0;
    end else begin
      if (pix.valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({pix.valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      pix.credit <= pop;
    end
  end

endmodule

// File: logic/gfx_engine_top.sv
`timescale 1ns/1ps

module gfx_engine_top (
  input  logic              cpu_clk_g,
  input  logic              rst_n,
  input  logic              cmd_valid,
  input  gfx_pkg::cmd_sel_t cmd_sel,
  input  logic [31:0]       cmd_data,
  output logic              busy,
  output logic              fb_we,
  output gfx_pkg::fb_addr_t fb_addr,
  output gfx_pkg::color_t   fb_data,
  input  logic              fb_ready
);
  import gfx_pkg::*;

  color_t color;
  coord_t x0, y0, x1, y1;
  logic   start_line, start_fill;
  logic   stepping, draining;

  pixel_if pix_if ();

  // Busy until the stepper is done and the last write has left
  assign busy = stepping || draining;

  gfx_cmd_regs gfx_cmd_regs_inst (
    .cpu_clk_g   (cpu_clk_g),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_sel     (cmd_sel),
    .cmd_data    (cmd_data),
    .engine_busy (busy),
    .color       (color),
    .x0          (x0),
    .y0          (y0),
    .x1          (x1),
    .y1          (y1),
    .start_line  (start_line),
    .start_fill  (start_fill)
  );

  line_stepper line_stepper_inst (
    .cpu_clk_g  (cpu_clk_g),
    .rst_n      (rst_n),
    .start_line (start_line),
    .start_fill (start_fill),
    .color      (color),
    .x0         (x0),
    .y0         (y0),
    .x1         (x1),
    .y1         (y1),
    .pix        (pix_if.src),
    .stepping   (stepping)
  );

  pixel_addr_gen pixel_addr_gen_inst (
    .cpu_clk_g (cpu_clk_g),
    .rst_n     (rst_n),
    .pix       (pix_if.dst),
    .fb_we     (fb_we),
    .fb_addr   (fb_addr),
    .fb_data   (fb_data),
    .fb_ready  (fb_ready),
    .draining  (draining)
  );

endmodule

// File: tests/gfx_tb.sv
`timescale 1ns/1ps
`include "gfx_settings.svh"

module gfx_tb;
  import gfx_pkg::*;

  localparam int WAIT_LIMIT = 20000;

  logic        cpu_clk_g;
  logic        rst_n;
  logic        cmd_valid;
  cmd_sel_t    cmd_sel;
  logic [31:0] cmd_data;
  logic        busy;
  logic        fb_we;
  fb_addr_t    fb_addr;
  color_t      fb_data;
  logic        fb_ready;

  integer   seed;
  int       ready_mode;
  int       stretch_left;
  logic     stretch_level;
  string    test_name;
  fb_addr_t exp_addr [$];
  color_t   exp_color [$];
  fb_addr_t want_addr;
  color_t   want_color;
  logic     held;
  fb_addr_t held_addr;
  color_t   held_data;
  color_t   fill_color;
  color_t   late_color;

  gfx_engine_top gfx_engine_top_inst (
    .cpu_clk_g (cpu_clk_g),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_sel   (cmd_sel),
    .cmd_data  (cmd_data),
    .busy      (busy),
    .fb_we     (fb_we),
    .fb_addr   (fb_addr),
    .fb_data   (fb_data),
    .fb_ready  (fb_ready)
  );

  initial cpu_clk_g = 1'b0;
  always #4 cpu_clk_g = ~cpu_clk_g;

  task automatic report_failure(input string what);
    $display("Failure in %s: %s", test_name, what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_addr(input string name, input fb_addr_t expected, input fb_addr_t actual);
    if (actual !== expected) begin
      $display("Error in %s: expected address 0x%04h, actual 0x%04h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_color(input string name, input color_t expected, input color_t actual);
    if (actual !== expected) begin
      $display("Error in %s: expected colour 0x%08h, actual 0x%08h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "colour mismatch");
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Each model pixel is clipped to the screen and given a row-major address
  task automatic model_pixel(input int x, input int y, input color_t c);
    if (x >= 0 && x < `GFX_FB_WIDTH && y >= 0 && y < `GFX_FB_HEIGHT) begin
      exp_addr.push_back(fb_addr_t'(y * `GFX_FB_WIDTH + x));
      exp_color.push_back(c);
    end
  endtask

  task automatic model_line(input int ax, input int ay, input int bx, input int by,
                            input color_t c);
    int x, y, dx, dy, sx, sy, err, e2;
    x   = ax;
    y   = ay;
    dx  = (bx > ax) ? bx - ax : ax - bx;
    dy  = (by > ay) ? ay - by : by - ay;
    sx  = (bx >= ax) ? 1 : -1;
    sy  = (by >= ay) ? 1 : -1;
    err = dx + dy;
    model_pixel(x, y, c);
    while (x != bx || y != by) begin
      e2 = 2 * err;
      if (e2 >= dy) begin
        err += dy;
        x   += sx;
      end
      if (e2 <= dx) begin
        err += dx;
        y   += sy;
      end
      model_pixel(x, y, c);
    end
  endtask

  task automatic model_fill(input color_t c);
    for (int y = 0; y < `GFX_FB_HEIGHT; y++) begin
      for (int x = 0; x < `GFX_FB_WIDTH; x++) begin
        model_pixel(x, y, c);
      end
    end
  endtask

  // The DUT samples this register write at the second edge
  task automatic send_cmd(input cmd_sel_t sel, input logic [31:0] data);
    @(posedge cpu_clk_g);
    cmd_valid <= 1'b1;
    cmd_sel   <= sel;
    cmd_data  <= data;
    @(posedge cpu_clk_g);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge cpu_clk_g);
    while (busy) begin
      if (cycles == WAIT_LIMIT) report_failure("busy never fell after the command");
      else begin
        @(negedge cpu_clk_g);
        cycles++;
      end
    end
    cycles = 0;
    while (exp_addr.size() != 0) begin
      if (cycles == 16) report_failure("expected pixels were never written");
      else begin
        @(negedge cpu_clk_g);
        cycles++;
      end
    end
  endtask

  task automatic draw_line(input int ax, input int ay, input int bx, input int by,
                           input color_t c);
    send_cmd(SEL_COLOR, c);
    send_cmd(SEL_X0, 32'(ax));
    send_cmd(SEL_Y0, 32'(ay));
    send_cmd(SEL_X1, 32'(bx));
    send_cmd(SEL_Y1, 32'(by));
    model_line(ax, ay, bx, by, c);
    send_cmd(SEL_LINE, 32'd0);
    wait_idle();
  endtask

  task automatic random_lines(input int n, input int lo, input int hi_x, input int hi_y);
    for (int i = 0; i < n; i++) begin
      draw_line(rand_range(lo, hi_x), rand_range(lo, hi_y), rand_range(lo, hi_x),
                rand_range(lo, hi_y), color_t'($random(seed)));
    end
  endtask

  task automatic draw_fill(input color_t c);
    send_cmd(SEL_COLOR, c);
    model_fill(c);
    send_cmd(SEL_FILL, 32'd0);
    wait_idle();
  endtask

  // fb_ready is always high, mostly high, in long stretches or held low
  initial begin
    fb_ready      <= 1'b1;
    stretch_left  = 0;
    stretch_level = 1'b1;
    forever begin
      @(posedge cpu_clk_g);
      if (ready_mode == 0) begin
        fb_ready <= 1'b1;
      end else if (ready_mode == 1) begin
        fb_ready <= (($random(seed) & 3) != 0);
      end else if (ready_mode == 3) begin
        fb_ready <= 1'b0;
      end else begin
        if (stretch_left == 0) begin
          stretch_level = !stretch_level;
          stretch_left  = stretch_level ? rand_range(1, 6) : rand_range(4, 24);
        end else begin
          stretch_left--;
        end
        fb_ready <= stretch_level;
      end
    end
  end

  // Monitor of accepted writes and of a stalled write holding still
  always @(posedge cpu_clk_g) begin
    if (rst_n) begin
      if (held && !fb_we) report_failure("fb_we dropped while a write was waiting");
      else if (held) begin
        check_addr({test_name, " hold"}, held_addr, fb_addr);
        check_color({test_name, " hold"}, held_data, fb_data);
      end
      if (fb_we && fb_ready) begin
        if (exp_addr.size() == 0) report_failure("frame-buffer write with no pixel expected");
        else begin
          want_addr  = exp_addr.pop_front();
          want_color = exp_color.pop_front();
          check_addr(test_name, want_addr, fb_addr);
          check_color(test_name, want_color, fb_data);
        end
      end
      held      = fb_we && !fb_ready;
      held_addr = fb_addr;
      held_data = fb_data;
    end
  end

  initial begin
    seed        = 83218;
    ready_mode  = 0;
    held        = 1'b0;
    test_name   = "reset";
    rst_n      <= 1'b0;
    cmd_valid  <= 1'b0;
    cmd_sel    <= '0;
    cmd_data   <= '0;
    repeat (2) @(posedge cpu_clk_g);
    rst_n <= 1'b1;
    @(negedge cpu_clk_g);
    if (busy || fb_we) report_failure("busy or fb_we high after reset");

    test_name = "single_pixel";
    draw_line(5, 7, 5, 7, 32'hcafe_0042);

    test_name  = "random_lines";
    ready_mode = 1;
    random_lines(40, 0, `GFX_FB_WIDTH - 1, `GFX_FB_HEIGHT - 1);

    test_name  = "fill";
    ready_mode = 0;
    draw_fill(32'h00ff_8800);

    test_name  = "backpressure";
    ready_mode = 2;
    random_lines(20, 0, `GFX_FB_WIDTH - 1, `GFX_FB_HEIGHT - 1);
    draw_fill(32'h1234_5678);

    test_name  = "clipped_lines";
    ready_mode = 1;
    draw_line(-5, -3, 20, 14, 32'h0000_00aa);
    draw_line(30, -8, -12, 20, 32'h0000_00bb);
    random_lines(30, -20, 35, 31);

    // Trigger and colour change during a fill must not disturb it
    test_name  = "busy_drop";
    fill_color = 32'h5a5a_a5a5;
    late_color = 32'h0bad_f00d;
    send_cmd(SEL_COLOR, fill_color);
    model_fill(fill_color);
    send_cmd(SEL_FILL, 32'd0);
    send_cmd(SEL_COLOR, late_color);
    send_cmd(SEL_X0, 32'd3);
    send_cmd(SEL_Y0, 32'd4);
    send_cmd(SEL_X1, 32'd3);
    send_cmd(SEL_Y1, 32'd4);
    send_cmd(SEL_LINE, 32'd0);
    @(negedge cpu_clk_g);
    if (!busy) report_failure("fill ended before the second trigger was issued");
    wait_idle();

    // A trigger that arrives as the stepper finishes must be dropped too
    model_pixel(3, 4, late_color);
    ready_mode = 3;
    send_cmd(SEL_LINE, 32'd0);
    send_cmd(SEL_LINE, 32'd0);
    @(negedge cpu_clk_g);
    if (!busy) report_failure("busy fell while the pixel write was held back");
    ready_mode = 0;
    wait_idle();

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: list.f
+incdir+logic
logic/gfx_pkg.sv
logic/pixel_if.sv
logic/gfx_cmd_regs.sv
logic/line_stepper.sv
logic/pixel_addr_gen.sv
logic/gfx_engine_top.sv
tests/gfx_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module gfx_tb -f list.f -o gfx_sim

status=0
output=$(./obj_dir/gfx_sim 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
  exit 0
fi
echo "simulation exited with status $status"
exit 1
